// ==== common/cam_reg_pkg.sv ====
// config register map of the LFIB CAM, word addressed
// all registers are 32 bits wide, counters are read-only
`default_nettype none

package cam_reg_pkg;

    localparam int REG_WIDTH = 32;

    // word addresses
    typedef enum logic [7:0] {
        CTRL         = 8'd0,
        ENTRY_ID     = 8'd1,
        LOOKUP_COUNT = 8'd3,
        HIT_COUNT    = 8'd4,
        MISS_COUNT   = 8'd5,
        DATA0        = 8'd16,
        DATA1        = 8'd17
    } reg_addr_e;

    // CTRL bit positions
    localparam int CTRL_RD_BIT     = 0;
    localparam int CTRL_WR_BIT     = 1;
    localparam int CTRL_RST_BIT    = 2;
    localparam int CTRL_IN_USE_BIT = 31;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } cfg_op_e;

    // one config access, held stable for the whole handshake
    typedef struct packed {
        cfg_op_e                op;
        reg_addr_e              addr;
        logic [REG_WIDTH-1:0]   wdata;
    } cfg_req_t;

endpackage

`default_nettype wire

// ==== common/lfib_pkg.sv ====
// label, action and lookup types of the LFIB
// entry ids in a lookup result are 6 bits, so at most 64 entries
`default_nettype none

package lfib_pkg;

    localparam int LABEL_W   = 20;
    localparam int RESP_ID_W = 6;

    typedef enum logic [2:0] {
        MPLS_POP  = 3'd0,
        LSR_SWAP  = 3'd1,
        LSR_NOOP  = 3'd2,
        DROP      = 3'd3,
        NO_ACTION = 3'd4
    } lfib_action_e;

    // what a hit returns
    typedef struct packed {
        lfib_action_e           action;
        logic [LABEL_W-1:0]     label_out;
    } lfib_value_t;

    typedef struct packed {
        logic [LABEL_W-1:0]     key;
        lfib_value_t            value;
    } lfib_entry_t;

    typedef struct packed {
        logic                   valid;
        logic [LABEL_W-1:0]     label;
    } lookup_req_t;

    // miss returns NO_ACTION with label and id 0
    typedef struct packed {
        logic                   valid;
        logic                   hit;
        logic [RESP_ID_W-1:0]   entry_id;
        lfib_action_e           action;
        logic [LABEL_W-1:0]     label_out;
    } lookup_resp_t;

endpackage

`default_nettype wire

// ==== tiny_bcam/bcam_entry_store.sv ====
// entry table with in-use bits, read and match are combinational
// write and clear land on the clock edge, clear wins over write
`default_nettype none
`timescale 1ns/1ps

module bcam_entry_store #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                                    core_clk_ifc,
    input  logic                                    rst,
    input  logic                                    wr_en,
    input  logic [$clog2(NUM_ENTRIES)-1:0]          wr_id,
    input  lfib_pkg::lfib_entry_t                   wr_entry,
    input  logic                                    clr_all,
    input  logic [$clog2(NUM_ENTRIES)-1:0]          rd_id,
    input  logic [lfib_pkg::LABEL_W-1:0]            match_key,
    output lfib_pkg::lfib_entry_t                   rd_entry,
    output logic                                    rd_in_use,
    output logic [NUM_ENTRIES-1:0]                  match_vec,
    output lfib_pkg::lfib_value_t [NUM_ENTRIES-1:0] entry_values
);

    lfib_pkg::lfib_entry_t  entries [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] in_use;

    //////////////////////////////////////////////////////////////////////
    // storage

    always_ff @(posedge core_clk_ifc) begin
        if (wr_en && !clr_all) begin
            entries[wr_id] <= wr_entry;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            in_use <= '0;
        end else if (clr_all) begin
            in_use <= '0;
        end else if (wr_en) begin
            in_use[wr_id] <= 1'b1;
        end
    end

    // entry read port for the config side
    assign rd_entry  = entries[rd_id];
    assign rd_in_use = in_use[rd_id];

    //////////////////////////////////////////////////////////////////////
    // parallel compare, stale keys are masked by in_use

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            match_vec[i]    = in_use[i] && (entries[i].key == match_key);
            entry_values[i] = entries[i].value;
        end
    end

    // the register block resolves WR and RST into one command
    a_no_wr_with_clr: assert property (
        @(posedge core_clk_ifc) disable iff (rst)
        !(wr_en && clr_all)
    );

endmodule

`default_nettype wire

// ==== tiny_bcam/bcam_match_pipe.sv ====
// two-stage lookup, a new request may enter every cycle
// lowest matching entry id wins
`default_nettype none
`timescale 1ns/1ps

module bcam_match_pipe #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                                    core_clk_ifc,
    input  logic                                    rst,
    input  lfib_pkg::lookup_req_t                   lookup_req,
    input  logic [NUM_ENTRIES-1:0]                  match_vec,
    input  lfib_pkg::lfib_value_t [NUM_ENTRIES-1:0] entry_values,
    output logic [lfib_pkg::LABEL_W-1:0]            match_key,
    output lfib_pkg::lookup_resp_t                  lookup_resp
);

    localparam int ID_W = $clog2(NUM_ENTRIES);

    logic                           s1_valid;
    logic [lfib_pkg::LABEL_W-1:0]   s1_label;
    logic                           hit_any;
    logic [ID_W-1:0]                hit_id;
    lfib_pkg::lookup_resp_t         resp_next;

    //////////////////////////////////////////////////////////////////////
    // stage 1, register the label

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= lookup_req.valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        s1_label <= lookup_req.label;
    end

    // the store compares against the table as it is this cycle
    assign match_key = s1_label;

    //////////////////////////////////////////////////////////////////////
    // stage 2, priority encode and format

    always_comb begin
        hit_any = |match_vec;
        hit_id  = '0;
        // scan downward so the lowest set bit is the last one taken
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit_id = ID_W'(i);
            end
        end
    end

    always_comb begin
        resp_next           = '0;
        resp_next.valid     = s1_valid;
        resp_next.hit       = s1_valid && hit_any;
        resp_next.action    = lfib_pkg::NO_ACTION;
        if (resp_next.hit) begin
            resp_next.entry_id[ID_W-1:0] = hit_id;
            resp_next.action             = entry_values[hit_id].action;
            resp_next.label_out          = entry_values[hit_id].label_out;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            lookup_resp.valid <= 1'b0;
            lookup_resp.hit   <= 1'b0;
        end else begin
            lookup_resp <= resp_next;
        end
    end

    // a hit two cycles on must come from a valid request
    a_hit_needs_valid: assert property (
        @(posedge core_clk_ifc) disable iff (rst)
        lookup_resp.hit |-> (lookup_resp.valid && $past(lookup_req.valid, 2))
    );

endmodule

`default_nettype wire

// ==== rtl/cam_reg_block.sv ====
// four-phase config slave, every access happens on the edge that raises ack
// counters clear only on rst
`default_nettype none
`timescale 1ns/1ps

module cam_reg_block #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                                core_clk_ifc,
    input  logic                                rst,
    input  logic                                req,
    input  cam_reg_pkg::cfg_req_t               cfg_req,
    input  lfib_pkg::lookup_resp_t              result,
    input  lfib_pkg::lfib_entry_t               rd_entry,
    input  logic                                rd_in_use,
    output logic                                ack,
    output logic [cam_reg_pkg::REG_WIDTH-1:0]   rdata,
    output logic                                wr_en,
    output logic [$clog2(NUM_ENTRIES)-1:0]      wr_id,
    output lfib_pkg::lfib_entry_t               wr_entry,
    output logic                                clr_all,
    output logic [$clog2(NUM_ENTRIES)-1:0]      rd_id
);

    localparam int ID_W = $clog2(NUM_ENTRIES);
    localparam int RW   = cam_reg_pkg::REG_WIDTH;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } hs_state_e;

    hs_state_e              state;
    logic                   access;
    logic                   reg_wr;
    logic                   ctrl_wr;
    logic                   load;
    logic [ID_W-1:0]        entry_id_q;
    lfib_pkg::lfib_entry_t  stage_q;
    logic                   in_use_q;
    logic [RW-1:0]          lookup_cnt;
    logic [RW-1:0]          hit_cnt;
    logic [RW-1:0]          miss_cnt;
    logic [RW-1:0]          rd_mux;

    //////////////////////////////////////////////////////////////////////
    // handshake

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (req) state <= ACK;
                ACK:       state <= req ? WAIT_DROP : IDLE;
                WAIT_DROP: if (!req) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    assign ack = (state != IDLE);

    // one access per handshake
    assign access  = (state == IDLE) && req;
    assign reg_wr  = access && (cfg_req.op == cam_reg_pkg::WRITE);
    assign ctrl_wr = reg_wr && (cfg_req.addr == cam_reg_pkg::CTRL);

    // RST beats WR when both bits are set
    assign clr_all = ctrl_wr && cfg_req.wdata[cam_reg_pkg::CTRL_RST_BIT];
    assign wr_en   = ctrl_wr && cfg_req.wdata[cam_reg_pkg::CTRL_WR_BIT] && !clr_all;
    assign load    = ctrl_wr && cfg_req.wdata[cam_reg_pkg::CTRL_RD_BIT];

    assign wr_id    = entry_id_q;
    assign rd_id    = entry_id_q;
    assign wr_entry = stage_q;

    //////////////////////////////////////////////////////////////////////
    // staging registers

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            entry_id_q <= '0;
            stage_q    <= '0;
            in_use_q   <= 1'b0;
        end else if (load) begin
            stage_q  <= rd_entry;
            in_use_q <= rd_in_use;
        end else if (reg_wr) begin
            case (cfg_req.addr)
                cam_reg_pkg::ENTRY_ID: entry_id_q <= cfg_req.wdata[ID_W-1:0];
                cam_reg_pkg::DATA0:    stage_q.key <= cfg_req.wdata[lfib_pkg::LABEL_W-1:0];
                cam_reg_pkg::DATA1: begin
                    stage_q.value.action    <= lfib_pkg::lfib_action_e'(cfg_req.wdata[2:0]);
                    stage_q.value.label_out <= cfg_req.wdata[8 +: lfib_pkg::LABEL_W];
                end
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // statistics, one cycle behind the result

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            lookup_cnt <= '0;
            hit_cnt    <= '0;
            miss_cnt   <= '0;
        end else if (result.valid) begin
            lookup_cnt <= lookup_cnt + 1'b1;
            if (result.hit) begin
                hit_cnt <= hit_cnt + 1'b1;
            end else begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read back, held for the whole ack phase

    always_comb begin
        rd_mux = '0;
        case (cfg_req.addr)
            cam_reg_pkg::CTRL:         rd_mux[cam_reg_pkg::CTRL_IN_USE_BIT] = in_use_q;
            cam_reg_pkg::ENTRY_ID:     rd_mux[ID_W-1:0] = entry_id_q;
            cam_reg_pkg::LOOKUP_COUNT: rd_mux = lookup_cnt;
            cam_reg_pkg::HIT_COUNT:    rd_mux = hit_cnt;
            cam_reg_pkg::MISS_COUNT:   rd_mux = miss_cnt;
            cam_reg_pkg::DATA0:        rd_mux[lfib_pkg::LABEL_W-1:0] = stage_q.key;
            cam_reg_pkg::DATA1: begin
                rd_mux[2:0]                   = stage_q.value.action;
                rd_mux[8 +: lfib_pkg::LABEL_W] = stage_q.value.label_out;
            end
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge core_clk_ifc) begin
        if (access) begin
            rdata <= rd_mux;
        end
    end

    a_ack_after_req: assert property (
        @(posedge core_clk_ifc) disable iff (rst)
        $rose(ack) |-> $past(req)
    );

    a_req_stable: assert property (
        @(posedge core_clk_ifc) disable iff (rst)
        (req && $past(req)) |-> $stable(cfg_req)
    );

endmodule

`default_nettype wire

// ==== rtl/lfib_top.sv ====
// LFIB on a binary CAM, NUM_ENTRIES a power of two from 4 to 64
// lookup result 2 cycles after request, no back-pressure
`default_nettype none
`timescale 1ns/1ps

module lfib_top #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                                core_clk_ifc,
    input  logic                                rst,
    input  logic                                req,
    input  cam_reg_pkg::cfg_req_t               cfg_req,
    input  lfib_pkg::lookup_req_t               lookup_req,
    output logic                                ack,
    output logic [cam_reg_pkg::REG_WIDTH-1:0]   rdata,
    output lfib_pkg::lookup_resp_t              lookup_resp
);

    localparam int ID_W = $clog2(NUM_ENTRIES);

    // config side to the store
    logic                                       wr_en;
    logic [ID_W-1:0]                            wr_id;
    lfib_pkg::lfib_entry_t                      wr_entry;
    logic                                       clr_all;
    logic [ID_W-1:0]                            rd_id;
    lfib_pkg::lfib_entry_t                      rd_entry;
    logic                                       rd_in_use;

    // lookup side
    logic [lfib_pkg::LABEL_W-1:0]               match_key;
    logic [NUM_ENTRIES-1:0]                     match_vec;
    lfib_pkg::lfib_value_t [NUM_ENTRIES-1:0]    entry_values;

    cam_reg_block #(
        .NUM_ENTRIES ( NUM_ENTRIES )
    ) reg_block (
        .core_clk_ifc ( core_clk_ifc ),
        .rst          ( rst          ),
        .req          ( req          ),
        .cfg_req      ( cfg_req      ),
        .result       ( lookup_resp  ),
        .rd_entry     ( rd_entry     ),
        .rd_in_use    ( rd_in_use    ),
        .ack          ( ack          ),
        .rdata        ( rdata        ),
        .wr_en        ( wr_en        ),
        .wr_id        ( wr_id        ),
        .wr_entry     ( wr_entry     ),
        .clr_all      ( clr_all      ),
        .rd_id        ( rd_id        )
    );

    bcam_entry_store #(
        .NUM_ENTRIES ( NUM_ENTRIES )
    ) entry_store (
        .core_clk_ifc ( core_clk_ifc ),
        .rst          ( rst          ),
        .wr_en        ( wr_en        ),
        .wr_id        ( wr_id        ),
        .wr_entry     ( wr_entry     ),
        .clr_all      ( clr_all      ),
        .rd_id        ( rd_id        ),
        .match_key    ( match_key    ),
        .rd_entry     ( rd_entry     ),
        .rd_in_use    ( rd_in_use    ),
        .match_vec    ( match_vec    ),
        .entry_values ( entry_values )
    );

    bcam_match_pipe #(
        .NUM_ENTRIES ( NUM_ENTRIES )
    ) match_pipe (
        .core_clk_ifc ( core_clk_ifc ),
        .rst          ( rst          ),
        .lookup_req   ( lookup_req   ),
        .match_vec    ( match_vec    ),
        .entry_values ( entry_values ),
        .match_key    ( match_key    ),
        .lookup_resp  ( lookup_resp  )
    );

endmodule

`default_nettype wire

// ==== verif/lfib_checker.sv ====
// reference model of the LFIB registers, table and counters
// checks each lookup result two edges after its request and every config read
`default_nettype none
`timescale 1ns/1ps

module lfib_checker #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                    core_clk_ifc,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    ack,
    input  cam_reg_pkg::cfg_req_t   cfg_req,
    input  logic [31:0]             rdata,
    input  lfib_pkg::lookup_req_t   lookup_req,
    input  lfib_pkg::lookup_resp_t  lookup_resp,
    input  logic                    exp_en,
    input  logic [31:0]             exp_rdata,
    output int                      lookup_errs,
    output int                      rdata_errs
);

    localparam int ID_W = $clog2(NUM_ENTRIES);

    lfib_pkg::lfib_entry_t  ent [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] used;
    // entries whose contents were ever written
    logic [NUM_ENTRIES-1:0] known;
    lfib_pkg::lfib_entry_t  stage;
    logic                   key_ok;
    logic                   val_ok;
    logic                   in_use_r;
    logic [ID_W-1:0]        eid;
    logic [31:0]            n_lookup;
    logic [31:0]            n_hit;
    logic [31:0]            n_miss;
    lfib_pkg::lookup_resp_t exp_pipe [2];
    logic                   rd_pending;
    logic                   rd_known;
    logic                   rd_tab_en;
    logic [31:0]            rd_model;
    logic [31:0]            rd_tab;
    int                     lk_errs = 0;
    int                     rd_errs = 0;

    assign lookup_errs = lk_errs;
    assign rdata_errs  = rd_errs;

    // first matching entry in id order
    function automatic lfib_pkg::lookup_resp_t lookup_expect(input logic [19:0] label);
        lfib_pkg::lookup_resp_t r;
        r        = '0;
        r.valid  = 1'b1;
        r.action = lfib_pkg::NO_ACTION;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!r.hit && used[i] && ent[i].key == label) begin
                r.hit       = 1'b1;
                r.entry_id  = 6'(i);
                r.action    = ent[i].value.action;
                r.label_out = ent[i].value.label_out;
            end
        end
        return r;
    endfunction

    task automatic expect_read(input cam_reg_pkg::reg_addr_e addr);
        rd_model = '0;
        rd_known = 1'b1;
        case (addr)
            cam_reg_pkg::CTRL:         rd_model[31] = in_use_r;
            cam_reg_pkg::ENTRY_ID:     rd_model[ID_W-1:0] = eid;
            cam_reg_pkg::LOOKUP_COUNT: rd_model = n_lookup;
            cam_reg_pkg::HIT_COUNT:    rd_model = n_hit;
            cam_reg_pkg::MISS_COUNT:   rd_model = n_miss;
            cam_reg_pkg::DATA0: begin
                rd_model[19:0] = stage.key;
                rd_known       = key_ok;
            end
            cam_reg_pkg::DATA1: begin
                rd_model[2:0]  = stage.value.action;
                rd_model[27:8] = stage.value.label_out;
                rd_known       = val_ok;
            end
            default: ;
        endcase
    endtask

    // a load sees the entry as it was before a commit in the same write
    task automatic apply_write(input cam_reg_pkg::cfg_req_t c);
        lfib_pkg::lfib_entry_t old_e;
        logic                  old_u;
        logic                  old_k;
        old_e = ent[eid];
        old_u = used[eid];
        old_k = known[eid];
        case (c.addr)
            cam_reg_pkg::ENTRY_ID: eid = c.wdata[ID_W-1:0];
            cam_reg_pkg::DATA0: begin
                stage.key = c.wdata[19:0];
                key_ok    = 1'b1;
            end
            cam_reg_pkg::DATA1: begin
                stage.value.action    = lfib_pkg::lfib_action_e'(c.wdata[2:0]);
                stage.value.label_out = c.wdata[27:8];
                val_ok                = 1'b1;
            end
            cam_reg_pkg::CTRL: begin
                if (c.wdata[cam_reg_pkg::CTRL_RST_BIT]) begin
                    used = '0;
                end else if (c.wdata[cam_reg_pkg::CTRL_WR_BIT]) begin
                    ent[eid]   = stage;
                    used[eid]  = 1'b1;
                    known[eid] = key_ok && val_ok;
                end
                if (c.wdata[cam_reg_pkg::CTRL_RD_BIT]) begin
                    stage    = old_e;
                    key_ok   = old_k;
                    val_ok   = old_k;
                    in_use_r = old_u;
                end
            end
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // per-edge compare

    always @(posedge core_clk_ifc) begin : compare
        lfib_pkg::lookup_resp_t want;
        if (rst) begin
            used        = '0;
            known       = '0;
            stage       = '0;
            key_ok      = 1'b1;
            val_ok      = 1'b1;
            in_use_r    = 1'b0;
            eid         = '0;
            n_lookup    = '0;
            n_hit       = '0;
            n_miss      = '0;
            exp_pipe[0] = '0;
            exp_pipe[1] = '0;
            rd_pending  = 1'b0;
        end else begin
            // rdata of the access one edge back
            if (rd_pending) begin
                if (ack !== 1'b1) begin
                    rd_errs++;
                    $display("config read at %0t ns got no ack in the cycle after req", $time);
                end else begin
                    if (rd_known && rdata !== rd_model) begin
                        rd_errs++;
                        $display("Mismatch at %0t ns: rdata %h, model expects %h",
                                 $time, rdata, rd_model);
                    end
                    if (rd_tab_en && rdata !== rd_tab) begin
                        rd_errs++;
                        $display("Mismatch at %0t ns: rdata %h, table expects %h",
                                 $time, rdata, rd_tab);
                    end
                end
            end
            rd_pending = 1'b0;
            if (req === 1'b1 && ack === 1'b0) begin
                if (cfg_req.op == cam_reg_pkg::READ) begin
                    expect_read(cfg_req.addr);
                    rd_tab_en  = exp_en;
                    rd_tab     = exp_rdata;
                    rd_pending = 1'b1;
                end else begin
                    apply_write(cfg_req);
                end
            end
            want = exp_pipe[1];
            if (lookup_resp.valid !== want.valid || (want.valid && lookup_resp !== want)) begin
                lk_errs++;
                $display("Mismatch at %0t ns: lookup result %h, expected %h",
                         $time, lookup_resp, want);
            end
            if (want.valid) begin
                n_lookup++;
                if (want.hit) begin
                    n_hit++;
                end else begin
                    n_miss++;
                end
            end
            exp_pipe[1] = exp_pipe[0];
            exp_pipe[0] = (lookup_req.valid === 1'b1) ? lookup_expect(lookup_req.label) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== verif/lfib_tb.sv ====
// rows of the stimulus table run in order against lfib_top
// lookup rows go out back to back and config rows use the four-phase handshake
`default_nettype none
`timescale 1ns/1ps

module lfib_tb;

    localparam int NUM_ENTRIES = 32;
    localparam logic [31:0] CMD_RD  = 32'd1 << cam_reg_pkg::CTRL_RD_BIT;
    localparam logic [31:0] CMD_WR  = 32'd1 << cam_reg_pkg::CTRL_WR_BIT;
    localparam logic [31:0] CMD_RST = 32'd1 << cam_reg_pkg::CTRL_RST_BIT;

    // one table row holds a config access or a lookup label
    typedef struct packed {
        logic                   is_lookup;
        cam_reg_pkg::cfg_req_t  cfg;
        logic                   chk;
        logic [31:0]            exp;
        logic [19:0]            label;
    } row_t;

    logic                   core_clk_ifc;
    logic                   rst;
    logic                   req;
    cam_reg_pkg::cfg_req_t  cfg_req;
    lfib_pkg::lookup_req_t  lookup_req;
    logic                   ack;
    logic [31:0]            rdata;
    lfib_pkg::lookup_resp_t lookup_resp;
    logic                   exp_en;
    logic [31:0]            exp_rdata;
    int                     lookup_errs;
    int                     rdata_errs;
    row_t                   rows[$];
    integer                 seed = 32'h7dcb;
    logic                   table_ready = 1'b0;

    lfib_top #(
        .NUM_ENTRIES ( NUM_ENTRIES )
    ) uut (
        .core_clk_ifc ( core_clk_ifc ),
        .rst          ( rst          ),
        .req          ( req          ),
        .cfg_req      ( cfg_req      ),
        .lookup_req   ( lookup_req   ),
        .ack          ( ack          ),
        .rdata        ( rdata        ),
        .lookup_resp  ( lookup_resp  )
    );

    lfib_checker #(
        .NUM_ENTRIES ( NUM_ENTRIES )
    ) model_check (
        .core_clk_ifc ( core_clk_ifc ),
        .rst          ( rst          ),
        .req          ( req          ),
        .ack          ( ack          ),
        .cfg_req      ( cfg_req      ),
        .rdata        ( rdata        ),
        .lookup_req   ( lookup_req   ),
        .lookup_resp  ( lookup_resp  ),
        .exp_en       ( exp_en       ),
        .exp_rdata    ( exp_rdata    ),
        .lookup_errs  ( lookup_errs  ),
        .rdata_errs   ( rdata_errs   )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    //////////////////////////////////////////////////////////////////////
    // table building

    task automatic write_row(input cam_reg_pkg::reg_addr_e addr, input logic [31:0] data);
        row_t r;
        r           = '0;
        r.cfg.op    = cam_reg_pkg::WRITE;
        r.cfg.addr  = addr;
        r.cfg.wdata = data;
        rows.push_back(r);
    endtask

    // chk 0 leaves the value to the checker's model
    task automatic read_row(input cam_reg_pkg::reg_addr_e addr, input logic chk,
                            input logic [31:0] exp);
        row_t r;
        r          = '0;
        r.cfg.op   = cam_reg_pkg::READ;
        r.cfg.addr = addr;
        r.chk      = chk;
        r.exp      = exp;
        rows.push_back(r);
    endtask

    task automatic lookup_row(input logic [19:0] label);
        row_t r;
        r           = '0;
        r.is_lookup = 1'b1;
        r.label     = label;
        rows.push_back(r);
    endtask

    // programmed keys never start with E
    task automatic miss_row();
        lookup_row({4'he, 16'($random(seed))});
    endtask

    function automatic logic [31:0] data1_word(input lfib_pkg::lfib_action_e action,
                                               input logic [19:0] label_out);
        return {4'b0, label_out, 5'b0, action};
    endfunction

    task automatic program_entry(input int id, input logic [19:0] key,
                                 input lfib_pkg::lfib_action_e action,
                                 input logic [19:0] label_out);
        write_row(cam_reg_pkg::ENTRY_ID, 32'(id));
        write_row(cam_reg_pkg::DATA0, {12'b0, key});
        write_row(cam_reg_pkg::DATA1, data1_word(action, label_out));
        write_row(cam_reg_pkg::CTRL, CMD_WR);
    endtask

    task automatic build_table();
        // empty table with counters at zero
        read_row(cam_reg_pkg::LOOKUP_COUNT, 1'b1, 32'd0);
        read_row(cam_reg_pkg::HIT_COUNT, 1'b1, 32'd0);
        read_row(cam_reg_pkg::MISS_COUNT, 1'b1, 32'd0);
        lookup_row(20'h12345);
        miss_row();
        miss_row();
        program_entry(0, 20'h12345, lfib_pkg::LSR_SWAP, 20'h00111);
        program_entry(3, 20'h0abcd, lfib_pkg::MPLS_POP, 20'h00000);
        program_entry(7, 20'h55555, lfib_pkg::DROP, 20'h22222);
        program_entry(31, 20'h0f00f, lfib_pkg::LSR_NOOP, 20'h33333);
        lookup_row(20'h12345);
        lookup_row(20'h0abcd);
        lookup_row(20'h55555);
        lookup_row(20'h0f00f);
        miss_row();
        lookup_row(20'h12345);
        // duplicate keys where the lower id must win
        program_entry(12, 20'h55555, lfib_pkg::LSR_SWAP, 20'h44444);
        program_entry(2, 20'h0f00f, lfib_pkg::MPLS_POP, 20'h55555);
        lookup_row(20'h55555);
        lookup_row(20'h0f00f);
        // entry read back
        write_row(cam_reg_pkg::ENTRY_ID, 32'd7);
        write_row(cam_reg_pkg::CTRL, CMD_RD);
        read_row(cam_reg_pkg::DATA0, 1'b1, 32'h55555);
        read_row(cam_reg_pkg::DATA1, 1'b1, data1_word(lfib_pkg::DROP, 20'h22222));
        read_row(cam_reg_pkg::CTRL, 1'b1, 32'h8000_0000);
        read_row(cam_reg_pkg::ENTRY_ID, 1'b1, 32'd7);
        write_row(cam_reg_pkg::ENTRY_ID, 32'd20);
        write_row(cam_reg_pkg::CTRL, CMD_RD);
        read_row(cam_reg_pkg::CTRL, 1'b1, 32'd0);
        // clear and then every key misses
        write_row(cam_reg_pkg::CTRL, CMD_RST);
        lookup_row(20'h12345);
        lookup_row(20'h0abcd);
        lookup_row(20'h55555);
        lookup_row(20'h0f00f);
        // gives the last results time to reach the counters
        read_row(cam_reg_pkg::ENTRY_ID, 1'b0, 32'd0);
        read_row(cam_reg_pkg::LOOKUP_COUNT, 1'b1, 32'd15);
        read_row(cam_reg_pkg::HIT_COUNT, 1'b1, 32'd7);
        read_row(cam_reg_pkg::MISS_COUNT, 1'b1, 32'd8);
    endtask

    //////////////////////////////////////////////////////////////////////
    // driving

    // starts 1 ns after a rising edge and ends the same way with ack low
    task automatic run_cfg(input row_t r);
        cfg_req   = r.cfg;
        exp_en    = r.chk;
        exp_rdata = r.exp;
        req       = 1'b1;
        do begin
            @(posedge core_clk_ifc);
            #1;
        end while (ack !== 1'b1);
        req = 1'b0;
        do begin
            @(posedge core_clk_ifc);
            #1;
        end while (ack !== 1'b0);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors: lookup %0d, rdata %0d", lookup_errs, rdata_errs);
        if (!timed_out && lookup_errs == 0 && rdata_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        rst        = 1'b1;
        req        = 1'b0;
        cfg_req    = '0;
        lookup_req = '0;
        exp_en     = 1'b0;
        exp_rdata  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge core_clk_ifc);
        #1;
        rst = 1'b0;
        foreach (rows[i]) begin
            @(posedge core_clk_ifc);
            #1;
            if (rows[i].is_lookup) begin
                lookup_req = {1'b1, rows[i].label};
            end else begin
                lookup_req = '0;
                run_cfg(rows[i]);
            end
        end
        @(posedge core_clk_ifc);
        #1;
        lookup_req = '0;
        // drain the lookup pipe
        repeat (4) @(posedge core_clk_ifc);
        finish_run(1'b0);
    end

    initial begin : watchdog
        wait (table_ready === 1'b1);
        repeat (rows.size() * 10 + 100) @(posedge core_clk_ifc);
        $display("run timed out after %0d clock periods", rows.size() * 10 + 100);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lfib_tb \
    -f all.f -o lfib_sim > build.log 2>&1 \
    && ./obj_dir/lfib_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== all.f ====
common/cam_reg_pkg.sv
common/lfib_pkg.sv
tiny_bcam/bcam_entry_store.sv
tiny_bcam/bcam_match_pipe.sv
rtl/cam_reg_block.sv
rtl/lfib_top.sv
verif/lfib_checker.sv
verif/lfib_tb.sv
